// File: hw/accel_pkg.sv
`default_nettype none

package accel_pkg;

  //////////////////////////////
  // widths and counts.
  //////////////////////////////

  localparam int IO_DATA_WIDTH   = 32;
  localparam int IO_ADDR_WIDTH   = 9;
  localparam int DATA_WIDTH      = 64;
  localparam int BYTES_PER_LINE  = 8;
  localparam int PMEM_ADDR_WIDTH = 12;
  localparam int LINE_ADDR_WIDTH = PMEM_ADDR_WIDTH - $clog2(BYTES_PER_LINE);
  localparam int LEN_WIDTH       = 14;
  localparam int LINE_CNT_WIDTH  = LEN_WIDTH - $clog2(BYTES_PER_LINE) + 1;
  localparam int ACCEL_COUNT     = 4;
  localparam int ACCEL_ID_WIDTH  = 2;
  localparam int USER_WIDTH      = 3;  // valid bytes on the last line, 0 is a full line.

  localparam int HASH_WIDTH      = 32;
  localparam int HASH_KEY_WIDTH  = 320;
  localparam int HASH_OFS_MAX    = HASH_KEY_WIDTH - HASH_WIDTH;

  localparam logic [HASH_KEY_WIDTH-1:0] HASH_KEY =
    320'h6d5a56da255b0ec24167253d43a38fb0d0ca2bcbae7b30b477cb2da38030f20c6a42b73bbeac01fa;

  localparam logic [31:0] SIG_PATTERN = 32'hc0de_f00d;  // first byte on top.

  //////////////////////////////
  // address map.
  //////////////////////////////

  localparam logic [IO_ADDR_WIDTH-1:0] HASH_CLEAR_OFS = 9'h100;
  localparam logic [IO_ADDR_WIDTH-1:0] HASH_LEN1_OFS  = 9'h104;
  localparam logic [IO_ADDR_WIDTH-1:0] HASH_LEN2_OFS  = 9'h108;
  localparam logic [IO_ADDR_WIDTH-1:0] HASH_LEN4_OFS  = 9'h10c;
  localparam logic [IO_ADDR_WIDTH-1:0] STATUS_OFS     = 9'h080;

  localparam int ACCEL_STRIDE   = 'h10;
  localparam int ACCEL_OFS_BITS = $clog2(ACCEL_STRIDE);

  localparam logic [ACCEL_OFS_BITS-1:0] CTRL_OFS = 4'h0;
  localparam logic [ACCEL_OFS_BITS-1:0] LEN_OFS  = 4'h4;
  localparam logic [ACCEL_OFS_BITS-1:0] ADDR_OFS = 4'h8;

  typedef struct packed {
    logic [ACCEL_ID_WIDTH-1:0]  accel_id;
    logic [PMEM_ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]       len;
    logic                       valid;
  } dma_desc_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0]     data;
    logic [USER_WIDTH-1:0]     user;
    logic                      last;
    logic [ACCEL_ID_WIDTH-1:0] accel_id;
  } line_beat_t;

  typedef struct packed {
    logic [7:0]                data;
    logic                      last;
    logic [ACCEL_ID_WIDTH-1:0] accel_id;
  } byte_beat_t;

  typedef struct packed {
    logic [HASH_WIDTH-1:0] data;
    logic [1:0]            len;  // 1, 2, or 0 for four bytes.
    logic                  valid;
    logic                  clear;
  } hash_in_t;

endpackage

`default_nettype wire

// File: hw/accel_regs.sv
`timescale 1ns/100ps
`default_nettype none

module accel_regs (
  input  wire                                      clk,
  input  wire                                      rst,
  input  wire                                      io_en,
  input  wire                                      io_wen,
  input  wire [accel_pkg::IO_DATA_WIDTH/8-1:0]     io_strb,
  input  wire [accel_pkg::IO_ADDR_WIDTH-1:0]       io_addr,
  input  wire [accel_pkg::IO_DATA_WIDTH-1:0]       io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]      io_rd_data,
  output logic                                     io_rd_valid,
  output accel_pkg::dma_desc_t                     desc,
  input  wire                                      dma_busy,
  output logic [accel_pkg::ACCEL_COUNT-1:0]        start_mask,
  output logic [accel_pkg::ACCEL_COUNT-1:0]        stop_mask,
  input  wire accel_pkg::byte_beat_t               byte_beat,
  input  wire [accel_pkg::ACCEL_COUNT-1:0]         match_pulse,
  output accel_pkg::hash_in_t                      hash_in,
  input  wire [accel_pkg::HASH_WIDTH-1:0]          hash_out
);
  import accel_pkg::*;

  logic [LEN_WIDTH-1:0]       len_reg  [ACCEL_COUNT];
  logic [PMEM_ADDR_WIDTH-1:0] addr_reg [ACCEL_COUNT];
  logic [ACCEL_COUNT-1:0]     status_done;
  logic [ACCEL_COUNT-1:0]     status_match;
  logic                       hash_rd_stall;

  wire [IO_ADDR_WIDTH-1:0]  word_addr = {io_addr[IO_ADDR_WIDTH-1:2], 2'b00};
  wire [ACCEL_ID_WIDTH-1:0] id        = io_addr[ACCEL_OFS_BITS +: ACCEL_ID_WIDTH];
  wire [ACCEL_OFS_BITS-1:0] reg_ofs   = word_addr[ACCEL_OFS_BITS-1:0];
  wire acc_sel  = io_addr[IO_ADDR_WIDTH-1:ACCEL_OFS_BITS+ACCEL_ID_WIDTH] == '0;
  wire hash_sel = word_addr >= HASH_CLEAR_OFS;
  wire wr       = io_en && io_wen;
  wire rd       = io_en && !io_wen;

  // hash result lags a data or clear strobe by one cycle.
  wire hash_busy = hash_in.valid || hash_in.clear;

  // a match pulse in flight shows up together with done.
  wire [ACCEL_COUNT-1:0] match_now = status_match | match_pulse;
  wire [ACCEL_COUNT-1:0] last_mask = byte_beat.last ?
                                     ACCEL_COUNT'(1) << byte_beat.accel_id : '0;

  //////////////////////////////
  // writes and command strobes.
  //////////////////////////////

  always_ff @(posedge clk) begin
    desc.valid    <= 1'b0;
    start_mask    <= '0;
    stop_mask     <= '0;
    hash_in.valid <= 1'b0;
    hash_in.clear <= 1'b0;

    if (wr && hash_sel) begin
      hash_in.data <= io_wr_data;
      case (word_addr)
        HASH_CLEAR_OFS: hash_in.clear <= 1'b1;
        HASH_LEN1_OFS: begin
          hash_in.len   <= 2'd1;
          hash_in.valid <= 1'b1;
        end
        HASH_LEN2_OFS: begin
          hash_in.len   <= 2'd2;
          hash_in.valid <= 1'b1;
        end
        HASH_LEN4_OFS: begin
          hash_in.len   <= 2'd0;
          hash_in.valid <= 1'b1;
        end
        default: ;
      endcase
    end else if (wr && acc_sel) begin
      case (reg_ofs)
        CTRL_OFS: begin
          if (io_strb[0] && io_wr_data[4]) begin
            stop_mask[id] <= 1'b1;  // stop wins over start.
          end else if (io_strb[0] && io_wr_data[0]) begin
            start_mask[id] <= 1'b1;
            desc.valid     <= 1'b1;
            desc.accel_id  <= id;
            desc.addr      <= addr_reg[id];
            desc.len       <= len_reg[id];
          end
        end
        LEN_OFS:  len_reg[id]  <= io_wr_data[LEN_WIDTH-1:0];
        ADDR_OFS: addr_reg[id] <= io_wr_data[PMEM_ADDR_WIDTH-1:0];
        default: ;
      endcase
    end

    if (rst) begin
      desc.valid    <= 1'b0;
      start_mask    <= '0;
      stop_mask     <= '0;
      hash_in.valid <= 1'b0;
      hash_in.clear <= 1'b0;
    end
  end

  //////////////////////////////
  // read mux and status flags.
  //////////////////////////////

  always_ff @(posedge clk) begin
    io_rd_valid   <= 1'b0;
    hash_rd_stall <= 1'b0;

    if (rd) begin
      io_rd_data  <= '0;
      io_rd_valid <= 1'b1;
      if (hash_sel) begin
        io_rd_data    <= hash_out;
        io_rd_valid   <= !hash_busy;
        hash_rd_stall <= hash_busy;
      end else if (word_addr == STATUS_OFS) begin
        io_rd_data[ACCEL_COUNT-1:0]  <= status_done;
        io_rd_data[8 +: ACCEL_COUNT] <= match_now;
      end else if (acc_sel) begin
        case (reg_ofs)
          CTRL_OFS: begin
            io_rd_data[1] <= dma_busy;
            io_rd_data[8] <= status_done[id];
            io_rd_data[9] <= match_now[id];
          end
          LEN_OFS:  io_rd_data[LEN_WIDTH-1:0]       <= len_reg[id];
          ADDR_OFS: io_rd_data[PMEM_ADDR_WIDTH-1:0] <= addr_reg[id];
          default: ;
        endcase
      end
    end

    if (hash_rd_stall) begin
      io_rd_data  <= hash_out;
      io_rd_valid <= 1'b1;
    end

    status_done  <= (status_done | last_mask | stop_mask) & ~start_mask;
    status_match <= (status_match | match_pulse) & ~start_mask;

    if (rst) begin
      io_rd_valid   <= 1'b0;
      hash_rd_stall <= 1'b0;
      status_done   <= '0;
      status_match  <= '0;
    end
  end

  assert property (@(posedge clk) disable iff (rst) (start_mask & stop_mask) == '0);

endmodule

`default_nettype wire

// File: hw/accel_rd_dma.sv
`timescale 1ns/100ps
`default_nettype none

module accel_rd_dma (
  input  wire                                      clk,
  input  wire                                      rst,
  input  wire accel_pkg::dma_desc_t                desc,
  input  wire [accel_pkg::ACCEL_COUNT-1:0]         stop_mask,
  output logic                                     dma_busy,
  output logic                                     mem_rd_en,
  output logic [accel_pkg::LINE_ADDR_WIDTH-1:0]    mem_rd_addr,
  input  wire [accel_pkg::DATA_WIDTH-1:0]          mem_rd_data,
  output logic                                     line_valid,
  input  wire                                      line_ready,
  output accel_pkg::line_beat_t                    line_beat
);
  import accel_pkg::*;

  logic [ACCEL_ID_WIDTH-1:0] cur_id;
  logic [USER_WIDTH-1:0]     cur_user;
  logic [LINE_CNT_WIDTH-1:0] rd_left;   // lines still to be read.
  logic                      rd_inflight;
  logic                      rd_last;
  line_beat_t                skid [2];
  logic                      wr_ptr;
  logic                      rd_ptr;
  logic [1:0]                fill;

  wire accept = desc.valid && !dma_busy;
  wire abort  = dma_busy && stop_mask[cur_id];
  wire xfer   = line_valid && line_ready;
  wire push   = rd_inflight && !abort;

  // round the byte length up to whole lines.
  wire [LEN_WIDTH:0] len_ext = {1'b0, desc.len} + (LEN_WIDTH+1)'(BYTES_PER_LINE - 1);
  wire [LINE_CNT_WIDTH-1:0] desc_lines = len_ext[LEN_WIDTH:$clog2(BYTES_PER_LINE)];

  // a read needs a skid entry that no earlier read has claimed.
  assign mem_rd_en  = dma_busy && rd_left != '0 && !abort &&
                      (fill + 2'(rd_inflight)) < 2'd2;
  assign line_valid = fill != 2'd0;
  assign line_beat  = skid[rd_ptr];

  //////////////////////////////
  // read issue.
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      dma_busy    <= desc.len != '0;  // zero-length descriptors are dropped.
      cur_id      <= desc.accel_id;
      cur_user    <= desc.len[USER_WIDTH-1:0];
      rd_left     <= desc_lines;
      mem_rd_addr <= desc.addr[PMEM_ADDR_WIDTH-1 -: LINE_ADDR_WIDTH];
    end
    if (mem_rd_en) begin
      rd_left     <= rd_left - 1'b1;
      mem_rd_addr <= mem_rd_addr + 1'b1;
    end
    rd_inflight <= mem_rd_en;
    rd_last     <= rd_left == LINE_CNT_WIDTH'(1);

    //////////////////////////////
    // skid buffer.
    //////////////////////////////

    if (push) begin
      skid[wr_ptr] <= '{data:     mem_rd_data,
                        user:     rd_last ? cur_user : '0,
                        last:     rd_last,
                        accel_id: cur_id};
      wr_ptr <= !wr_ptr;
    end
    if (xfer) begin
      rd_ptr <= !rd_ptr;
    end
    fill <= fill + 2'(push) - 2'(xfer);

    if (xfer && line_beat.last) begin
      dma_busy <= 1'b0;
    end

    if (abort) begin
      dma_busy <= 1'b0;
      rd_left  <= '0;
      fill     <= '0;
      rd_ptr   <= wr_ptr;  // drop buffered lines.
    end

    if (rst) begin
      dma_busy    <= 1'b0;
      rd_left     <= '0;
      rd_inflight <= 1'b0;
      wr_ptr      <= 1'b0;
      rd_ptr      <= 1'b0;
      fill        <= '0;
    end
  end

  assert property (@(posedge clk) disable iff (rst) mem_rd_en |-> dma_busy);

  assert property (@(posedge clk) disable iff (rst)
    line_valid && !line_ready && !abort |=> $stable(line_beat));

endmodule

`default_nettype wire

// File: hw/accel_width_conv.sv
`timescale 1ns/100ps
`default_nettype none

module accel_width_conv (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             line_valid,
  output logic                            line_ready,
  input  wire accel_pkg::line_beat_t      line_beat,
  output logic                            byte_valid,
  output accel_pkg::byte_beat_t           byte_beat
);
  import accel_pkg::*;

  line_beat_t            held;
  logic                  full;
  logic [USER_WIDTH-1:0] idx;
  logic [USER_WIDTH-1:0] end_idx;
  logic                  final_byte;

  // a user count of zero wraps round to the full line.
  assign end_idx    = held.last ? held.user - 1'b1 : USER_WIDTH'(BYTES_PER_LINE - 1);
  assign final_byte = full && idx == end_idx;
  assign line_ready = !full || final_byte;  // next line follows without a gap.

  assign byte_valid = full;
  assign byte_beat  = '{data:     held.data[8*idx +: 8],
                        last:     final_byte && held.last,
                        accel_id: held.accel_id};

  always_ff @(posedge clk) begin
    if (line_valid && line_ready) begin
      held <= line_beat;
      idx  <= '0;
      full <= 1'b1;
    end else if (final_byte) begin
      full <= 1'b0;
    end else if (full) begin
      idx <= idx + 1'b1;  // low byte first.
    end

    if (rst) begin
      full <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/sig_match.sv
`timescale 1ns/100ps
`default_nettype none

module sig_match #(
  parameter int MATCH_ID = 0
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              byte_valid,
  input  wire accel_pkg::byte_beat_t       byte_beat,
  input  wire [accel_pkg::ACCEL_COUNT-1:0] start_mask,
  output logic                             match_pulse
);
  import accel_pkg::*;

  logic [31:0] history;
  logic [2:0]  seen;  // bytes since start, stops at 4.

  wire        hit       = byte_valid && byte_beat.accel_id == ACCEL_ID_WIDTH'(MATCH_ID);
  wire [31:0] next_hist = {history[23:0], byte_beat.data};
  wire [2:0]  next_seen = (seen == 3'd4) ? seen : seen + 1'b1;

  always_ff @(posedge clk) begin
    match_pulse <= 1'b0;

    if (start_mask[MATCH_ID]) begin
      seen <= '0;  // no match across descriptors.
    end else if (hit) begin
      history     <= next_hist;
      seen        <= next_seen;
      match_pulse <= next_seen == 3'd4 && next_hist == SIG_PATTERN;
    end

    if (rst) begin
      seen        <= '0;
      match_pulse <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/toeplitz_hash.sv
`timescale 1ns/100ps
`default_nettype none

module toeplitz_hash (
  input  wire                              clk,
  input  wire                              rst,
  input  wire accel_pkg::hash_in_t         hash_in,
  output logic [accel_pkg::HASH_WIDTH-1:0] hash_out
);
  import accel_pkg::*;

  logic [8:0]                ofs;         // bit position in the key.
  logic [5:0]                nbits;
  logic [HASH_KEY_WIDTH-1:0] key_at_ofs;
  logic [HASH_WIDTH-1:0]     hash_next;

  assign nbits      = (hash_in.len == 2'd1) ? 6'd8 : (hash_in.len == 2'd2) ? 6'd16 : 6'd32;
  assign key_at_ofs = HASH_KEY << ofs;

  // each set input bit, msb first, folds in the key window at its offset.
  always_comb begin
    hash_next = hash_out;
    for (int j = 0; j < HASH_WIDTH; j++) begin
      if (j < nbits && hash_in.data[HASH_WIDTH-1-j]) begin
        hash_next = hash_next ^ key_at_ofs[HASH_KEY_WIDTH-1-j -: HASH_WIDTH];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hash_in.clear) begin
      hash_out <= '0;
      ofs      <= '0;
    end else if (hash_in.valid) begin
      hash_out <= hash_next;
      ofs      <= ofs + 9'(nbits);
    end

    if (rst) begin
      hash_out <= '0;
      ofs      <= '0;
    end
  end

  // the key covers at most 36 input bytes.
  assert property (@(posedge clk) disable iff (rst) ofs <= 9'(HASH_OFS_MAX));

endmodule

`default_nettype wire

// File: hw/accel_wrap.sv
`timescale 1ns/100ps
`default_nettype none

module accel_wrap (
  input  wire                                    clk,
  input  wire                                    rst,

  input  wire                                    io_en,
  input  wire                                    io_wen,
  input  wire [accel_pkg::IO_DATA_WIDTH/8-1:0]   io_strb,
  input  wire [accel_pkg::IO_ADDR_WIDTH-1:0]     io_addr,
  input  wire [accel_pkg::IO_DATA_WIDTH-1:0]     io_wr_data,
  output wire [accel_pkg::IO_DATA_WIDTH-1:0]     io_rd_data,
  output wire                                    io_rd_valid,

  output wire                                    mem_rd_en,
  output wire [accel_pkg::LINE_ADDR_WIDTH-1:0]   mem_rd_addr,
  input  wire [accel_pkg::DATA_WIDTH-1:0]        mem_rd_data
);
  import accel_pkg::*;

  wire dma_desc_t             desc;
  wire                        dma_busy;
  wire [ACCEL_COUNT-1:0]      start_mask;
  wire [ACCEL_COUNT-1:0]      stop_mask;
  wire [ACCEL_COUNT-1:0]      match_pulse;
  wire hash_in_t              hash_in;
  wire [HASH_WIDTH-1:0]       hash_out;
  wire                        line_valid;
  wire                        line_ready;
  wire line_beat_t            line_beat;
  wire                        byte_valid;
  wire byte_beat_t            byte_beat;

  accel_regs accel_regs_inst (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_strb     (io_strb),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid),
    .desc        (desc),
    .dma_busy    (dma_busy),
    .start_mask  (start_mask),
    .stop_mask   (stop_mask),
    .byte_beat   (byte_beat),
    .match_pulse (match_pulse),
    .hash_in     (hash_in),
    .hash_out    (hash_out)
  );

  accel_rd_dma accel_rd_dma_inst (
    .clk         (clk),
    .rst         (rst),
    .desc        (desc),
    .stop_mask   (stop_mask),
    .dma_busy    (dma_busy),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data),
    .line_valid  (line_valid),
    .line_ready  (line_ready),
    .line_beat   (line_beat)
  );

  accel_width_conv accel_width_conv_inst (
    .clk        (clk),
    .rst        (rst),
    .line_valid (line_valid),
    .line_ready (line_ready),
    .line_beat  (line_beat),
    .byte_valid (byte_valid),
    .byte_beat  (byte_beat)
  );

  // one matcher per id, all on the shared byte stream.
  for (genvar i = 0; i < ACCEL_COUNT; i++) begin : g_match
    sig_match #(
      .MATCH_ID (i)
    ) sig_match_inst (
      .clk         (clk),
      .rst         (rst),
      .byte_valid  (byte_valid),
      .byte_beat   (byte_beat),
      .start_mask  (start_mask),
      .match_pulse (match_pulse[i])
    );
  end

  toeplitz_hash toeplitz_hash_inst (
    .clk      (clk),
    .rst      (rst),
    .hash_in  (hash_in),
    .hash_out (hash_out)
  );

endmodule

`default_nettype wire

// File: dv/tb_accel_wrap.sv
`timescale 1ns/100ps
`default_nettype none

module tb_accel_wrap;
  import accel_pkg::*;

  localparam int RD_TIMEOUT = 8;
  localparam int POLL_LIMIT = 400;
  localparam int STOP_LIMIT = 16;

  logic                       clk;
  logic                       rst;
  logic                       io_en;
  logic                       io_wen;
  logic [IO_DATA_WIDTH/8-1:0] io_strb;
  logic [IO_ADDR_WIDTH-1:0]   io_addr;
  logic [IO_DATA_WIDTH-1:0]   io_wr_data;
  logic [IO_DATA_WIDTH-1:0]   io_rd_data;
  logic                       io_rd_valid;
  logic                       mem_rd_en;
  logic [LINE_ADDR_WIDTH-1:0] mem_rd_addr;
  logic [DATA_WIDTH-1:0]      mem_rd_data;

  logic [DATA_WIDTH-1:0]  mem [1 << LINE_ADDR_WIDTH];
  logic [15:0]            lfsr_state;
  int                     check_errors;
  int                     prop_errors;
  logic                   desc_active;  // a descriptor is running.
  int                     win_lo;
  int                     win_lines;
  int                     reads_base;
  int                     reads_total = 0;
  logic [ACCEL_COUNT-1:0] exp_done;
  logic [ACCEL_COUNT-1:0] exp_match;
  logic [HASH_WIDTH-1:0]  ref_hash;
  int                     ref_ofs;

  accel_wrap accel_wrap_inst (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_strb     (io_strb),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data)
  );

  always #50 clk = ~clk;

  // packet memory, one cycle read latency.
  always @(posedge clk) begin
    if (mem_rd_en) begin
      mem_rd_data <= mem[mem_rd_addr];
      reads_total <= reads_total + 1;
    end
  end

  //////////////////////////////
  // properties.
  //////////////////////////////

  assert property (@(posedge clk) $fell(rst) |-> !io_rd_valid && !mem_rd_en)
    else begin
      prop_errors++;
      $display("io_rd_valid or mem_rd_en high right after reset");
    end

  assert property (@(posedge clk) disable iff (rst) mem_rd_en |-> desc_active)
    else begin
      prop_errors++;
      $display("mem_rd_en high with no descriptor running");
    end

  assert property (@(posedge clk) disable iff (rst)
    mem_rd_en |-> reads_total - reads_base < win_lines)
    else begin
      prop_errors++;
      $display("memory read beyond the %0d lines of the descriptor", win_lines);
    end

  assert property (@(posedge clk) disable iff (rst)
    mem_rd_en |-> mem_rd_addr >= win_lo && mem_rd_addr < win_lo + win_lines)
    else begin
      prop_errors++;
      $display("Mismatch mem_rd_addr: %h outside %h to %h", mem_rd_addr, win_lo,
               win_lo + win_lines - 1);
    end

  //////////////////////////////
  // models.
  //////////////////////////////

  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic void set_byte(int a, logic [7:0] v);
    mem[a >> 3][8 * (a & 7) +: 8] = v;  // low byte of a line first.
  endfunction

  function automatic logic [7:0] get_byte(int a);
    return mem[a >> 3][8 * (a & 7) +: 8];
  endfunction

  function automatic void plant_sig(int a);
    for (int i = 0; i < 4; i++) begin
      set_byte(a + i, SIG_PATTERN[31 - 8 * i -: 8]);
    end
  endfunction

  function automatic logic expect_match(int base, int len);
    logic [31:0] hist;
    logic        hit;
    hist = '0;
    hit  = 1'b0;
    for (int i = 0; i < len; i++) begin
      hist = {hist[23:0], get_byte(base + i)};
      if (i >= 3 && hist == SIG_PATTERN) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic void hash_model_add(logic [31:0] data, int nbytes);
    logic [HASH_KEY_WIDTH-1:0] key;
    key = HASH_KEY;
    for (int b = 0; b < 8 * nbytes; b++) begin
      if (data[31 - b]) begin
        ref_hash = ref_hash ^ key[HASH_KEY_WIDTH - 1 - ref_ofs -: HASH_WIDTH];
      end
      ref_ofs++;
    end
  endfunction

  function automatic logic [31:0] status_word();
    return {20'b0, exp_match, 4'b0, exp_done};
  endfunction

  //////////////////////////////
  // I/O tasks.
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      check_errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // called on a falling edge, returns on a falling edge.
  task automatic io_write(input logic [IO_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = 4'hf;
    io_addr    = addr;
    io_wr_data = data;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic io_read(input logic [IO_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                         output int lat);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    lat   = 1;
    while (!io_rd_valid && lat < RD_TIMEOUT) begin
      @(negedge clk);
      lat++;
    end
    if (!io_rd_valid) begin
      check_errors++;
      $display("timed out waiting for io_rd_valid at address %h", addr);
    end
    data = io_rd_data;
  endtask

  task automatic check_regs;
    logic [31:0] rd;
    logic [31:0] lv;
    logic [31:0] av;
    int          lat;
    io_read(STATUS_OFS, rd, lat);
    check_value("status", rd, 32'h0);
    for (int id = 0; id < ACCEL_COUNT; id++) begin
      lv = rand_bits(LEN_WIDTH);
      av = rand_bits(PMEM_ADDR_WIDTH);
      io_write(id * ACCEL_STRIDE + LEN_OFS, lv);
      io_write(id * ACCEL_STRIDE + ADDR_OFS, av);
      io_read(id * ACCEL_STRIDE + LEN_OFS, rd, lat);
      check_value($sformatf("len[%0d]", id), rd, lv);
      check_value("len read latency", lat, 1);
      io_read(id * ACCEL_STRIDE + ADDR_OFS, rd, lat);
      check_value($sformatf("addr[%0d]", id), rd, av);
      check_value("addr read latency", lat, 1);
    end
  endtask

  // load and start a descriptor, checks that done and match were cleared.
  task automatic start_desc(input int id, input int addr, input int len);
    logic [31:0] rd;
    int          lat;
    int          base;
    base = id * ACCEL_STRIDE;
    io_write(base + LEN_OFS, len);
    io_write(base + ADDR_OFS, addr);
    win_lo      = addr >> 3;
    win_lines   = (len + 7) / 8;
    reads_base  = reads_total;
    desc_active = 1'b1;
    exp_done[id]  = 1'b0;
    exp_match[id] = 1'b0;
    io_write(base + CTRL_OFS, 32'h1);
    @(negedge clk);
    io_read(base + CTRL_OFS, rd, lat);
    check_value($sformatf("ctrl[%0d] match/done/busy", id), {rd[9:8], rd[1]}, 3'b001);
  endtask

  task automatic run_desc(input int id, input int addr, input int len);
    logic [31:0] rd;
    int          lat;
    int          polls;
    start_desc(id, addr, len);
    polls = 0;
    do begin
      io_read(id * ACCEL_STRIDE + CTRL_OFS, rd, lat);
      polls++;
    end while (!rd[8] && polls < POLL_LIMIT);
    if (!rd[8]) begin
      check_errors++;
      $display("timed out waiting for done on id %0d", id);
    end
    desc_active   = 1'b0;
    exp_done[id]  = 1'b1;
    exp_match[id] = expect_match(addr & ~7, len);
    io_read(STATUS_OFS, rd, lat);
    check_value("status", rd, status_word());
  endtask

  task automatic stop_long_desc(input int id, input int addr, input int len);
    logic [31:0] rd;
    int          lat;
    int          polls;
    start_desc(id, addr, len);
    repeat (20) @(negedge clk);
    io_write(id * ACCEL_STRIDE + CTRL_OFS, 32'h10);
    polls = 0;
    do begin
      io_read(id * ACCEL_STRIDE + CTRL_OFS, rd, lat);
      polls++;
    end while (rd[1] && polls < STOP_LIMIT);
    if (rd[1]) begin
      check_errors++;
      $display("busy did not clear after stop on id %0d", id);
    end
    desc_active  = 1'b0;
    exp_done[id] = 1'b1;  // no signature in this stream.
    io_read(STATUS_OFS, rd, lat);
    check_value("status", rd, status_word());
  endtask

  task automatic hash_clear;
    io_write(HASH_CLEAR_OFS, 32'h0);
    ref_hash = '0;
    ref_ofs  = 0;
  endtask

  task automatic hash_word(input int nbytes, input logic [31:0] data);
    case (nbytes)
      1: io_write(HASH_LEN1_OFS, data);
      2: io_write(HASH_LEN2_OFS, data);
      default: io_write(HASH_LEN4_OFS, data);
    endcase
    hash_model_add(data, nbytes);
  endtask

  task automatic check_hash;
    int          sizes [6];
    logic [31:0] rd;
    int          lat;
    sizes = '{1, 2, 4, 4, 2, 1};
    hash_clear();
    for (int k = 0; k < 6; k++) begin
      hash_word(sizes[k], rand_bits(32));
      @(negedge clk);
      io_read(HASH_CLEAR_OFS, rd, lat);
      check_value("hash_out", rd, ref_hash);
      check_value("hash read latency", lat, 1);
    end
    // reads right behind a data write.
    hash_clear();
    for (int k = 2; k < 5; k++) begin
      hash_word(sizes[k], rand_bits(32));
      io_read(HASH_CLEAR_OFS, rd, lat);
      check_value("hash_out", rd, ref_hash);
      check_value("stalled hash read latency", lat, 2);
    end
  endtask

  //////////////////////////////
  // sequence.
  //////////////////////////////

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    mem_rd_data  = '0;
    desc_active  = 1'b0;
    win_lo       = 0;
    win_lines    = 0;
    reads_base   = 0;
    exp_done     = '0;
    exp_match    = '0;
    ref_hash     = '0;
    ref_ofs      = 0;
    check_errors = 0;
    prop_errors  = 0;
    lfsr_state   = 16'd61143;

    for (int a = 0; a < (BYTES_PER_LINE << LINE_ADDR_WIDTH); a++) begin
      set_byte(a, rand_bits(8));
    end
    plant_sig('h04a);  // inside one line.
    plant_sig('h10e);  // across a line boundary.
    plant_sig('h313);  // runs past a 21 byte length.

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_regs();
    run_desc(0, 'h040, 32);
    run_desc(1, 'h100, 24);
    run_desc(2, 'h205, 40);
    run_desc(3, 'h300, 23);
    run_desc(3, 'h300, 21);
    check_hash();
    stop_long_desc(2, 'h400, 2048);
    run_desc(2, 'h040, 32);
    repeat (5) @(negedge clk);

    $display("check errors %0d, assertion errors %0d", check_errors, prop_errors);
    if (check_errors == 0 && prop_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/accel_pkg.sv
hw/accel_regs.sv
hw/accel_rd_dma.sv
hw/accel_width_conv.sv
hw/sig_match.sv
hw/toeplitz_hash.sv
hw/accel_wrap.sv
dv/tb_accel_wrap.sv
